// File: lv_pkg.sv
/*
 * shared widths, addresses and bus types for the lv register path
 * crc-4 is poly x^4+x+1, init 0, msb first over {addr, data}
 * address 15 is the status register, only 0..14 hold data
 */
package lv_pkg;

    //========================================
    // widths and addresses
    //========================================
    localparam int REG_AW    = 4;
    localparam int REG_DW    = 8;
    localparam int REG_CRC_W = 4;
    localparam int REG_NUM   = 16;

    localparam logic [REG_AW-1:0]    STATUS_ADDR = 4'd15;
    localparam logic [REG_AW-1:0]    SCAN_LAST   = 4'd14;
    localparam logic [REG_CRC_W-1:0] CRC_POLY    = 4'h3;   // x^4+x+1

    //========================================
    // host command, 17 bits, two views
    //========================================
    typedef struct packed {
        logic                 op;      // 1 = write
        logic [REG_AW-1:0]    addr;
        logic [REG_DW-1:0]    wdata;
        logic [REG_CRC_W-1:0] wcrc;
    } lv_wr_cmd_t;

    typedef struct packed {
        logic                          op;   // 0 = read
        logic [REG_AW-1:0]             addr;
        logic [REG_DW+REG_CRC_W-1:0]   pad;
    } lv_rd_cmd_t;

    typedef union packed {
        lv_wr_cmd_t wr;
        lv_rd_cmd_t rd;
    } lv_cmd_u;

    // internal four-phase bus
    typedef struct packed {
        logic                 req;
        logic                 wr;
        logic [REG_AW-1:0]    addr;
        logic [REG_DW-1:0]    wdata;
        logic [REG_CRC_W-1:0] wcrc;
    } lv_bus_req_t;

    typedef struct packed {
        logic                 ack;
        logic [REG_DW-1:0]    rdata;
        logic [REG_CRC_W-1:0] rcrc;
    } lv_bus_rsp_t;

    function automatic logic [REG_CRC_W-1:0] lv_crc4(
        input logic [REG_AW-1:0] addr,
        input logic [REG_DW-1:0] data
    );
        logic [REG_AW+REG_DW-1:0] msg;
        logic [REG_CRC_W-1:0]     crc;
        logic                     fb;
        msg = {addr, data};
        crc = '0;
        for (int i = REG_AW + REG_DW - 1; i >= 0; i--) begin
            fb  = crc[REG_CRC_W-1] ^ msg[i];
            crc = {crc[REG_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC_POLY;
            end
        end
        return crc;
    endfunction

endpackage

// File: lv_reg_slv.sv
`timescale 1ns/10ps
/*
 * register file, 15 entries of data + host supplied crc + valid bit
 * write crc is stored as given and never checked
 * address 15 reads {crc_err, 3'b000, fail_addr} with a computed crc,
 * a write to it pulses o_err_clr for one cycle
 * ack rises one cycle after req, falls one cycle after req drops
 */
module lv_reg_slv (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  lv_pkg::lv_bus_req_t              i_bus_req,
    output lv_pkg::lv_bus_rsp_t              o_bus_rsp,
    output logic [lv_pkg::REG_NUM-1:0]       o_entry_vld,
    output logic                             o_err_clr,
    input  logic                             i_crc_err,
    input  logic [lv_pkg::REG_AW-1:0]        i_fail_addr
);
    import lv_pkg::*;

    logic [REG_DW-1:0]       mem_data [REG_NUM-1];
    logic [REG_CRC_W-1:0]    mem_crc  [REG_NUM-1];
    logic [REG_NUM-2:0]      vld_q;
    logic                    ack_q;
    logic [REG_DW-1:0]       rdata_q;
    logic [REG_CRC_W-1:0]    rcrc_q;
    logic                    accept;
    logic                    is_status;
    logic [REG_DW-1:0]       status_byte;

    assign accept      = i_bus_req.req && !ack_q;     // first cycle of a request
    assign is_status   = (i_bus_req.addr == STATUS_ADDR);
    assign status_byte = {i_crc_err, 3'b000, i_fail_addr};

    //========================================
    // handshake and status clear
    //========================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q     <= 1'b0;
            o_err_clr <= 1'b0;
        end else begin
            if (accept) begin
                ack_q <= 1'b1;
            end else if (!i_bus_req.req) begin
                ack_q <= 1'b0;
            end
            o_err_clr <= accept && i_bus_req.wr && is_status;
        end
    end

    // entries start at zero and become valid once written
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < REG_NUM - 1; i++) begin
                mem_data[i] <= '0;
                mem_crc[i]  <= '0;
            end
            vld_q <= '0;
        end else if (accept && i_bus_req.wr && !is_status) begin
            mem_data[i_bus_req.addr] <= i_bus_req.wdata;
            mem_crc[i_bus_req.addr]  <= i_bus_req.wcrc;
            vld_q[i_bus_req.addr]    <= 1'b1;
        end
    end

    // read path
    always_ff @(posedge i_clk) begin
        if (accept && !i_bus_req.wr) begin
            if (is_status) begin
                rdata_q <= status_byte;
                rcrc_q  <= lv_crc4(STATUS_ADDR, status_byte);
            end else begin
                rdata_q <= mem_data[i_bus_req.addr];
                rcrc_q  <= mem_crc[i_bus_req.addr];
            end
        end
    end

    assign o_bus_rsp   = '{ack: ack_q, rdata: rdata_q, rcrc: rcrc_q};
    assign o_entry_vld = {1'b0, vld_q};   // status never scanned

    // the request must still be held when its ack rises
    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(ack_q) |-> i_bus_req.req)
        else $error("ack raised without a request");

endmodule

// File: lv_reg_arb.sv
`timescale 1ns/10ps
/*
 * two-requester arbiter onto the register bus
 * grants only from idle, host wins a tie
 * a grant lasts until that requester drops req, so one
 * transaction per grant; responses go to the granted side only
 * the grant register adds one cycle to the request path
 */
module lv_reg_arb (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  lv_pkg::lv_bus_req_t    i_host_req,
    output lv_pkg::lv_bus_rsp_t    o_host_rsp,
    input  lv_pkg::lv_bus_req_t    i_scan_req,
    output lv_pkg::lv_bus_rsp_t    o_scan_rsp,
    output lv_pkg::lv_bus_req_t    o_slv_req,
    input  lv_pkg::lv_bus_rsp_t    i_slv_rsp
);
    import lv_pkg::*;

    logic gnt_host;
    logic gnt_scan;
    logic gnt_idle;

    assign gnt_idle = !gnt_host && !gnt_scan;

    //========================================
    // grant state
    //========================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            gnt_host <= 1'b0;
            gnt_scan <= 1'b0;
        end else if (gnt_idle) begin
            if (i_host_req.req) begin
                gnt_host <= 1'b1;       // fixed priority
            end else if (i_scan_req.req) begin
                gnt_scan <= 1'b1;
            end
        end else begin
            // release once the owner ends its handshake
            if (gnt_host && !i_host_req.req) begin
                gnt_host <= 1'b0;
            end
            if (gnt_scan && !i_scan_req.req) begin
                gnt_scan <= 1'b0;
            end
        end
    end

    //========================================
    // bus mux and response routing
    //========================================
    always_comb begin
        o_slv_req  = '0;
        o_host_rsp = '0;
        o_scan_rsp = '0;
        if (gnt_host) begin
            o_slv_req  = i_host_req;
            o_host_rsp = i_slv_rsp;
        end else if (gnt_scan) begin
            o_slv_req  = i_scan_req;
            o_scan_rsp = i_slv_rsp;
        end
    end

    a_gnt_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(gnt_host && gnt_scan))
        else $error("both requesters granted");

endmodule

// File: lv_wdg_scan.sv
`timescale 1ns/10ps
/*
 * watchdog crc scan
 * reads addresses 0..SCAN_LAST in a loop, skipping entries never written
 * a crc mismatch sets a sticky error and keeps the first failing address
 * only reads are issued; i_err_clr clears error and address
 */
module lv_wdg_scan (
    input  logic                             i_clk,
    input  logic                             i_reset,
    output lv_pkg::lv_bus_req_t              o_bus_req,
    input  lv_pkg::lv_bus_rsp_t              i_bus_rsp,
    input  logic [lv_pkg::REG_NUM-1:0]       i_entry_vld,
    input  logic                             i_err_clr,
    output logic                             o_crc_err,
    output logic [lv_pkg::REG_AW-1:0]        o_fail_addr
);
    import lv_pkg::*;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_REQ  = 1'b1
    } st_e;

    st_e                 state;
    logic [REG_AW-1:0]   scan_addr;
    logic [REG_AW-1:0]   next_addr;
    logic                rd_done;
    logic                crc_bad;

    assign next_addr = (scan_addr == SCAN_LAST) ? '0 : scan_addr + 1'b1;
    assign rd_done   = (state == ST_REQ) && i_bus_rsp.ack;
    assign crc_bad   = (lv_crc4(scan_addr, i_bus_rsp.rdata) != i_bus_rsp.rcrc);

    //========================================
    // scan sequencing
    //========================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= ST_IDLE;
            scan_addr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_entry_vld[scan_addr]) begin
                        state <= ST_REQ;
                    end else begin
                        scan_addr <= next_addr;   // skip entries never written
                    end
                end
                ST_REQ: begin
                    if (i_bus_rsp.ack) begin
                        state     <= ST_IDLE;
                        scan_addr <= next_addr;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        o_bus_req      = '0;
        o_bus_req.req  = (state == ST_REQ);
        o_bus_req.addr = scan_addr;
    end

    // sticky error keeps the first failure
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_crc_err   <= 1'b0;
            o_fail_addr <= '0;
        end else if (i_err_clr) begin
            o_crc_err   <= 1'b0;
            o_fail_addr <= '0;
        end else if (rd_done && crc_bad && !o_crc_err) begin
            o_crc_err   <= 1'b1;
            o_fail_addr <= scan_addr;
        end
    end

endmodule

// File: lv_cmd_port.sv
`timescale 1ns/10ps
/*
 * host command port
 * takes one command per four-phase host handshake and runs it on the
 * internal bus; the bus request goes out the cycle after req is seen
 * read data is only meaningful while o_host_ack is high
 */
module lv_cmd_port (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             i_host_req,
    input  lv_pkg::lv_cmd_u                  i_host_cmd,
    output logic                             o_host_ack,
    output logic [lv_pkg::REG_DW-1:0]        o_host_rdata,
    output logic [lv_pkg::REG_CRC_W-1:0]     o_host_rcrc,
    output lv_pkg::lv_bus_req_t              o_bus_req,
    input  lv_pkg::lv_bus_rsp_t              i_bus_rsp
);
    import lv_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_BUS  = 2'd1,     // waiting on the arbiter / slave
        ST_HOST = 2'd2      // host ack high until req drops
    } st_e;

    st_e          state;
    lv_bus_req_t  dec_req;
    lv_bus_req_t  cmd_q;

    //========================================
    // command decode
    //========================================
    always_comb begin
        dec_req     = '0;
        dec_req.req = 1'b1;
        if (i_host_cmd.wr.op) begin
            dec_req.wr    = 1'b1;
            dec_req.addr  = i_host_cmd.wr.addr;
            dec_req.wdata = i_host_cmd.wr.wdata;
            dec_req.wcrc  = i_host_cmd.wr.wcrc;
        end else begin
            dec_req.addr  = i_host_cmd.rd.addr;   // pad not used
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (i_host_req) state <= ST_BUS;
                ST_BUS:  if (i_bus_rsp.ack) state <= ST_HOST;
                ST_HOST: if (!i_host_req) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // latched command and response data
    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_host_req) begin
            cmd_q <= dec_req;
        end
        if (state == ST_BUS && i_bus_rsp.ack) begin
            o_host_rdata <= i_bus_rsp.rdata;
            o_host_rcrc  <= i_bus_rsp.rcrc;
        end
    end

    always_comb begin
        o_bus_req     = cmd_q;
        o_bus_req.req = (state == ST_BUS);
    end

    assign o_host_ack = (state == ST_HOST);

    // host must not change the command before it sees the ack
    a_cmd_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_host_req && !o_host_ack) |=> (!(i_host_req && !o_host_ack) || $stable(i_host_cmd)))
        else $error("host command changed while request pending");

endmodule

// File: lv_core.sv
`timescale 1ns/10ps
/*
 * register path top: host command port, watchdog crc scan,
 * fixed priority arbiter and register file
 * host side is a four-phase req/ack, i_host_cmd held while req is high
 * o_crc_err is sticky until the host writes the status register
 */
module lv_core (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             i_host_req,
    input  lv_pkg::lv_cmd_u                  i_host_cmd,
    output logic                             o_host_ack,
    output logic [lv_pkg::REG_DW-1:0]        o_host_rdata,
    output logic [lv_pkg::REG_CRC_W-1:0]     o_host_rcrc,
    output logic                             o_crc_err
);
    import lv_pkg::*;

    lv_bus_req_t           cmd_bus_req;
    lv_bus_rsp_t           cmd_bus_rsp;
    lv_bus_req_t           scan_bus_req;
    lv_bus_rsp_t           scan_bus_rsp;
    lv_bus_req_t           slv_req;
    lv_bus_rsp_t           slv_rsp;
    logic [REG_NUM-1:0]    entry_vld;
    logic                  err_clr;
    logic [REG_AW-1:0]     fail_addr;

    lv_cmd_port u_cmd_port (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_host_req     (i_host_req),
        .i_host_cmd     (i_host_cmd),
        .o_host_ack     (o_host_ack),
        .o_host_rdata   (o_host_rdata),
        .o_host_rcrc    (o_host_rcrc),
        .o_bus_req      (cmd_bus_req),
        .i_bus_rsp      (cmd_bus_rsp)
    );

    lv_wdg_scan u_wdg_scan (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .o_bus_req      (scan_bus_req),
        .i_bus_rsp      (scan_bus_rsp),
        .i_entry_vld    (entry_vld),
        .i_err_clr      (err_clr),
        .o_crc_err      (o_crc_err),
        .o_fail_addr    (fail_addr)
    );

    lv_reg_arb u_reg_arb (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_host_req     (cmd_bus_req),
        .o_host_rsp     (cmd_bus_rsp),
        .i_scan_req     (scan_bus_req),
        .o_scan_rsp     (scan_bus_rsp),
        .o_slv_req      (slv_req),
        .i_slv_rsp      (slv_rsp)
    );

    lv_reg_slv u_reg_slv (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_bus_req      (slv_req),
        .o_bus_rsp      (slv_rsp),
        .o_entry_vld    (entry_vld),
        .o_err_clr      (err_clr),
        .i_crc_err      (o_crc_err),
        .i_fail_addr    (fail_addr)
    );

endmodule

// File: tb_lv_core.sv
`timescale 1ns/10ps
/*
 * testbench for lv_core, random stimulus from a 16-bit galois lfsr
 * reference model holds entries 0..14 plus the expected status byte
 * scan results are judged only after polling the status register
 * outputs are sampled on the falling clock edge
 */
module tb_lv_core;
    import lv_pkg::*;

    localparam int ACK_TIMEOUT = 100;   // cycles per handshake phase
    localparam int SETTLE_CYC  = 400;

    logic                  i_clk;
    logic                  i_reset;
    logic                  i_host_req;
    lv_cmd_u               i_host_cmd;
    logic                  o_host_ack;
    logic [REG_DW-1:0]     o_host_rdata;
    logic [REG_CRC_W-1:0]  o_host_rcrc;
    logic                  o_crc_err;

    logic [15:0]           lfsr_q;
    int                    cyc;
    int                    errors;
    int                    checks;
    int                    tests_pass;
    int                    tests_fail;

    // reference model
    logic [7:0]            model_data [15];
    logic [3:0]            model_crc  [15];
    logic                  model_err;
    logic [3:0]            model_fail;

    lv_core u_dut (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_host_req     (i_host_req),
        .i_host_cmd     (i_host_cmd),
        .o_host_ack     (o_host_ack),
        .o_host_rdata   (o_host_rdata),
        .o_host_rcrc    (o_host_rcrc),
        .o_crc_err      (o_crc_err)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) cyc <= cyc + 1;

    //========================================
    // random numbers and reference crc
    //========================================
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
            v = {v[14:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [3:0] rand_entry();
        logic [15:0] r;
        r = rand_bits(4) % 15;   // data entries only
        return r[3:0];
    endfunction

    // long division of {addr, data, 0000} by 10011
    function automatic logic [3:0] crc_ref(input logic [3:0] addr, input logic [7:0] data);
        logic [15:0] rem;
        rem = {addr, data, 4'h0};
        for (int i = 15; i >= 4; i--) begin
            if (rem[i]) begin
                rem[i -: 5] = rem[i -: 5] ^ 5'b10011;
            end
        end
        return rem[3:0];
    endfunction

    //========================================
    // checks and host handshake
    //========================================
    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic host_access(input logic wr, input logic [3:0] addr,
                               input logic [7:0] wdata, input logic [3:0] wcrc,
                               output logic [7:0] rdata, output logic [3:0] rcrc);
        lv_cmd_u     cmd;
        logic [15:0] pad;
        int          n;
        rdata = '0;
        rcrc  = '0;
        if (wr) begin
            cmd = {1'b1, addr, wdata, wcrc};
        end else begin
            pad = rand_bits(12);
            cmd = {1'b0, addr, pad[11:0]};   // pad is don't care
        end
        @(posedge i_clk);
        i_host_cmd <= cmd;
        i_host_req <= 1'b1;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_host_ack && n < ACK_TIMEOUT);
        if (!o_host_ack) begin
            $display("timeout: DUT never acked the access to address %0d", addr);
            errors++;
        end else begin
            rdata = o_host_rdata;
            rcrc  = o_host_rcrc;
        end
        @(posedge i_clk);
        i_host_req <= 1'b0;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (o_host_ack && n < ACK_TIMEOUT);
        if (o_host_ack) begin
            $display("timeout: DUT kept its ack high after the request dropped");
            errors++;
        end
    endtask

    task automatic write_entry(input logic [3:0] addr, input logic [7:0] data,
                               input logic [3:0] crc);
        logic [7:0] rd;
        logic [3:0] rc;
        host_access(1'b1, addr, data, crc, rd, rc);
        if (addr != STATUS_ADDR) begin
            model_data[addr] = data;
            model_crc[addr]  = crc;
        end else begin
            model_err  = 1'b0;   // status write clears
            model_fail = '0;
        end
    endtask

    task automatic read_check(input logic [3:0] addr);
        logic [7:0] exp_d;
        logic [3:0] exp_c;
        logic [7:0] rd;
        logic [3:0] rc;
        if (addr == STATUS_ADDR) begin
            exp_d = {model_err, 3'b000, model_fail};
            exp_c = crc_ref(addr, exp_d);
        end else begin
            exp_d = model_data[addr];
            exp_c = model_crc[addr];
        end
        host_access(1'b0, addr, 8'h00, 4'h0, rd, rc);
        check_val($sformatf("o_host_rdata[%0d]", addr), rd, exp_d);
        check_val($sformatf("o_host_rcrc[%0d]", addr), rc, exp_c);
    endtask

    // polls and checks the status register for SETTLE_CYC cycles
    task automatic settle_status();
        int start;
        start = cyc;
        while ((cyc - start) < SETTLE_CYC) begin
            read_check(STATUS_ADDR);
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            tests_pass++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_fail++;
            $display("test %0d %s: %0d errors", num, name, errors - err_before);
        end
    endtask

    //========================================
    // test sequence
    //========================================
    initial begin
        logic [3:0]  a;
        logic [3:0]  a1;
        logic [3:0]  a2;
        logic [3:0]  nz;
        logic [7:0]  d;
        logic [7:0]  rd;
        logic [3:0]  rc;
        logic        written [15];
        int          e0;
        int          start;
        i_clk      = 1'b0;
        i_reset    = 1'b1;
        i_host_req = 1'b0;
        i_host_cmd = '0;
        lfsr_q     = 16'd63544;
        cyc        = 0;
        errors     = 0;
        checks     = 0;
        tests_pass = 0;
        tests_fail = 0;
        model_err  = 1'b0;
        model_fail = '0;
        for (int i = 0; i < 15; i++) begin
            model_data[i] = '0;
            model_crc[i]  = '0;
            written[i]    = 1'b0;
        end
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;

        // good writes and read back
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            a = rand_entry();
            d = rand_bits(8);
            write_entry(a, d, crc_ref(a, d));
            written[a] = 1'b1;
        end
        for (int i = 0; i < 15; i++) begin
            if (written[i]) read_check(i[3:0]);
        end
        end_test(1, "write and read back", e0);

        // clean status
        e0 = errors;
        read_check(STATUS_ADDR);
        check_val("o_crc_err", o_crc_err, 1'b0);
        end_test(2, "status after good writes", e0);

        // one corrupted entry
        e0 = errors;
        a1 = rand_entry();
        d  = rand_bits(8);
        nz = rand_bits(4);
        if (nz == 4'h0) nz = 4'h1;
        write_entry(a1, d, crc_ref(a1, d) ^ nz);
        start = cyc;
        rd    = '0;
        while (!rd[7] && (cyc - start) < SETTLE_CYC) begin
            host_access(1'b0, STATUS_ADDR, 8'h00, 4'h0, rd, rc);
        end
        if (!rd[7]) begin
            $display("timeout: scan did not flag the bad entry at address %0d", a1);
            errors++;
        end
        model_err  = 1'b1;
        model_fail = a1;
        check_val("status fail_addr", rd[3:0], a1);
        check_val("o_host_rcrc[15]", rc, crc_ref(STATUS_ADDR, {4'h8, a1}));
        check_val("o_crc_err", o_crc_err, 1'b1);
        end_test(3, "single crc error", e0);

        // a second corruption keeps the first address
        e0 = errors;
        a2 = rand_entry();
        if (a2 == a1) a2 = (a1 == 4'd14) ? 4'd0 : a1 + 4'd1;
        d = rand_bits(8);
        write_entry(a2, d, crc_ref(a2, d) ^ 4'h5);
        settle_status();
        end_test(4, "first failure is sticky", e0);

        // repair entries and clear the flag for good
        e0 = errors;
        d = rand_bits(8);
        write_entry(a1, d, crc_ref(a1, d));
        d = rand_bits(8);
        write_entry(a2, d, crc_ref(a2, d));
        write_entry(STATUS_ADDR, rand_bits(8), 4'h0);
        read_check(STATUS_ADDR);
        settle_status();
        check_val("o_crc_err", o_crc_err, 1'b0);
        end_test(5, "status clear", e0);

        // random mix while the scan runs
        e0 = errors;
        for (int i = 0; i < 60; i++) begin
            if (rand_bits(1)) begin
                a = rand_entry();
                d = rand_bits(8);
                write_entry(a, d, crc_ref(a, d));
            end else begin
                read_check(rand_bits(4));
            end
        end
        check_val("o_crc_err", o_crc_err, 1'b0);
        end_test(6, "random mix", e0);

        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 tests_pass, tests_fail, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: lv_core.f
lv_pkg.sv
lv_reg_slv.sv
lv_reg_arb.sv
lv_wdg_scan.sv
lv_cmd_port.sv
lv_core.sv
tb_lv_core.sv
